//--- src/exec_alu.sv
// integer alu and branch compare
`timescale 1ns/10ps

module exec_alu (
  input  rv_exec_pkg::rdata_t  op1_i,
  input  rv_exec_pkg::rdata_t  op2_i,
  input  rv_exec_pkg::alu_op_t alu_op_i,
  input  rv_exec_pkg::branch_t branch_op_i,
  output rv_exec_pkg::rdata_t  res_o,
  output logic                 take_o
);
  import rv_exec_pkg::*;

  logic [4:0] shamt;

  // only the low five bits count for rv32 shifts
  assign shamt = op2_i[4:0];

  always_comb begin : alu
    case (alu_op_i)
      ALU_ADD:  res_o = op1_i + op2_i;
      ALU_SUB:  res_o = op1_i - op2_i;
      ALU_SLT:  res_o = rdata_t'($signed(op1_i) < $signed(op2_i));
      ALU_SLTU: res_o = rdata_t'(op1_i < op2_i);
      ALU_XOR:  res_o = op1_i ^ op2_i;
      ALU_OR:   res_o = op1_i | op2_i;
      ALU_AND:  res_o = op1_i & op2_i;
      ALU_SLL:  res_o = op1_i << shamt;
      ALU_SRL:  res_o = op1_i >> shamt;
      ALU_SRA:  res_o = rdata_t'($signed(op1_i) >>> shamt);
      default:  res_o = '0;
    endcase
  end : alu

  // compare on the same muxed operands
  always_comb begin : cmp
    case (branch_op_i)
      RV_B_BEQ:  take_o = (op1_i == op2_i);
      RV_B_BNE:  take_o = (op1_i != op2_i);
      RV_B_BLT:  take_o = ($signed(op1_i) < $signed(op2_i));
      RV_B_BGE:  take_o = ($signed(op1_i) >= $signed(op2_i));
      RV_B_BLTU: take_o = (op1_i < op2_i);
      RV_B_BGEU: take_o = (op1_i >= op2_i);
      default:   take_o = 1'b0;
    endcase
  end : cmp

endmodule

//--- src/exec_top.sv
// execute stage top level
`timescale 1ns/10ps

module exec_top (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic                 id_valid_i,
  input  rv_exec_pkg::rdata_t  pc_i,
  input  rv_exec_pkg::rdata_t  imm_i,
  input  rv_exec_pkg::raddr_t  rs1_addr_i,
  input  rv_exec_pkg::raddr_t  rs2_addr_i,
  input  rv_exec_pkg::raddr_t  rd_addr_i,
  input  rv_exec_pkg::op_sel_t rs1_op_i,
  input  rv_exec_pkg::op_sel_t rs2_op_i,
  input  rv_exec_pkg::alu_op_t alu_op_i,
  input  logic                 we_rd_i,
  input  logic                 branch_i,
  input  rv_exec_pkg::branch_t branch_op_i,
  input  logic                 jump_i,
  input  rv_exec_pkg::lsu_op_t lsu_op_i,
  input  rv_exec_pkg::lsu_w_t  lsu_w_i,
  input  logic                 lsu_bp_i,
  output logic                 id_ready_o,
  output rv_exec_pkg::rdata_t  result_o,
  output rv_exec_pkg::raddr_t  rd_addr_o,
  output logic                 we_rd_o,
  output logic                 fetch_req_o,
  output rv_exec_pkg::rdata_t  fetch_addr_o,
  output rv_exec_pkg::lsu_op_t lsu_op_o,
  output rv_exec_pkg::lsu_w_t  lsu_width_o,
  output rv_exec_pkg::rdata_t  lsu_addr_o,
  output rv_exec_pkg::rdata_t  lsu_wdata_o
);
  import rv_exec_pkg::*;

  id_ex_if  id_ex ();
  raddr_t   rs1_addr;
  raddr_t   rs2_addr;
  rdata_t   rs1_data;
  rdata_t   rs2_data;
  s_ex_wb_t ex_wb;
  logic     rf_we;

  assign id_ex.id_valid  = id_valid_i;
  assign id_ex.pc        = pc_i;
  assign id_ex.imm       = imm_i;
  assign id_ex.rs1_addr  = rs1_addr_i;
  assign id_ex.rs2_addr  = rs2_addr_i;
  assign id_ex.rd_addr   = rd_addr_i;
  assign id_ex.rs1_op    = rs1_op_i;
  assign id_ex.rs2_op    = rs2_op_i;
  assign id_ex.alu_op    = alu_op_i;
  assign id_ex.we_rd     = we_rd_i;
  assign id_ex.branch    = branch_i;
  assign id_ex.branch_op = branch_op_i;
  assign id_ex.jump      = jump_i;
  assign id_ex.lsu_op    = lsu_op_i;
  assign id_ex.lsu_w     = lsu_w_i;

  execute u_execute (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .id           (id_ex.dst),
    .rs1_addr_o   (rs1_addr),
    .rs2_addr_o   (rs2_addr),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .lsu_bp_i     (lsu_bp_i),
    .id_ready_o   (id_ready_o),
    .ex_wb_o      (ex_wb),
    .fetch_req_o  (fetch_req_o),
    .fetch_addr_o (fetch_addr_o),
    .lsu_op_o     (lsu_op_o),
    .lsu_w_o      (lsu_width_o),
    .lsu_addr_o   (lsu_addr_o),
    .lsu_wdata_o  (lsu_wdata_o)
  );

  // x0 writes dropped at the writeback port
  assign rf_we = ex_wb.we_rd && (ex_wb.rd_addr != '0);

  reg_file u_reg_file (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .we_i       (rf_we),
    .rd_addr_i  (ex_wb.rd_addr),
    .wdata_i    (ex_wb.result)
  );

  assign result_o  = ex_wb.result;
  assign rd_addr_o = ex_wb.rd_addr;
  assign we_rd_o   = ex_wb.we_rd;

endmodule

//--- src/execute.sv
// execute stage
`timescale 1ns/10ps

module execute (
  input  logic                  clk,
  input  logic                  rst_n_i,
  id_ex_if.dst                  id,
  output rv_exec_pkg::raddr_t   rs1_addr_o,
  output rv_exec_pkg::raddr_t   rs2_addr_o,
  input  rv_exec_pkg::rdata_t   rs1_data_i,
  input  rv_exec_pkg::rdata_t   rs2_data_i,
  input  logic                  lsu_bp_i,
  output logic                  id_ready_o,
  output rv_exec_pkg::s_ex_wb_t ex_wb_o,
  output logic                  fetch_req_o,
  output rv_exec_pkg::rdata_t   fetch_addr_o,
  output rv_exec_pkg::lsu_op_t  lsu_op_o,
  output rv_exec_pkg::lsu_w_t   lsu_w_o,
  output rv_exec_pkg::rdata_t   lsu_addr_o,
  output rv_exec_pkg::rdata_t   lsu_wdata_o
);
  import rv_exec_pkg::*;

  s_ex_wb_t ex_wb_ff;
  s_ex_wb_t next_ex_wb;
  rdata_t   wb_value;
  rdata_t   op1;
  rdata_t   op2;
  rdata_t   alu_res;
  logic     alu_take;
  logic     wb_fwd_ok;
  logic     rs1_fwd;
  logic     rs2_fwd;
  logic     st_fwd;
  logic     shadow;
  logic     br_take_ff;
  logic     next_br_take;
  rdata_t   br_addr_ff;
  rdata_t   next_br_addr;
  logic     jmp_act_ff;
  logic     next_jmp_act;
  rdata_t   jmp_addr_ff;
  rdata_t   next_jmp_addr;

  assign rs1_addr_o = id.rs1_addr;
  assign rs2_addr_o = id.rs2_addr;
  assign wb_value   = ex_wb_ff.result;

  // bypass from the instruction now in writeback
  assign wb_fwd_ok = ex_wb_ff.we_rd && (ex_wb_ff.rd_addr != '0);
  assign rs1_fwd   = wb_fwd_ok && (id.rs1_op == REG_RF) && (id.rs1_addr == ex_wb_ff.rd_addr);
  assign rs2_fwd   = wb_fwd_ok && (id.rs2_op == REG_RF) && (id.rs2_addr == ex_wb_ff.rd_addr);
  assign st_fwd    = wb_fwd_ok && (id.lsu_op == LSU_STORE) && (id.rs2_addr == ex_wb_ff.rd_addr);

  always_comb begin : op_mux
    case (id.rs1_op)
      REG_RF:  op1 = rs1_fwd ? wb_value : rs1_data_i;
      IMM:     op1 = id.imm;
      ZERO:    op1 = '0;
      PC:      op1 = id.pc;
      default: op1 = '0;
    endcase
    case (id.rs2_op)
      REG_RF:  op2 = rs2_fwd ? wb_value : rs2_data_i;
      IMM:     op2 = id.imm;
      ZERO:    op2 = '0;
      PC:      op2 = id.pc;
      default: op2 = '0;
    endcase
  end : op_mux

  exec_alu u_alu (
    .op1_i       (op1),
    .op2_i       (op2),
    .alu_op_i    (id.alu_op),
    .branch_op_i (id.branch_op),
    .res_o       (alu_res),
    .take_o      (alu_take)
  );

  // the cycle after a redirect still executes but must not write or redirect
  assign shadow = fetch_req_o;

  always_comb begin : wb_next
    next_ex_wb.result  = id.jump ? (id.pc + rdata_t'(4)) : alu_res;
    next_ex_wb.rd_addr = id.rd_addr;
    next_ex_wb.we_rd   = id.id_valid && id.we_rd && !shadow;
    if (lsu_bp_i) begin
      next_ex_wb = ex_wb_ff;
    end
  end : wb_next

  always_comb begin : redirect_next
    next_br_take  = id.id_valid && id.branch && alu_take && !lsu_bp_i && !shadow;
    next_br_addr  = id.pc + id.imm;
    next_jmp_act  = id.id_valid && id.jump && !lsu_bp_i && !shadow;
    // jalr target has bit 0 forced low
    next_jmp_addr = {alu_res[XLEN-1:1], 1'b0};
  end : redirect_next

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ex_wb_ff    <= EX_WB_RST;
      br_take_ff  <= 1'b0;
      br_addr_ff  <= '0;
      jmp_act_ff  <= 1'b0;
      jmp_addr_ff <= '0;
    end else begin
      ex_wb_ff    <= next_ex_wb;
      br_take_ff  <= next_br_take;
      br_addr_ff  <= next_br_addr;
      jmp_act_ff  <= next_jmp_act;
      jmp_addr_ff <= next_jmp_addr;
    end
  end

  assign id_ready_o   = ~lsu_bp_i;
  assign ex_wb_o      = ex_wb_ff;
  assign fetch_req_o  = br_take_ff || jmp_act_ff;
  assign fetch_addr_o = br_take_ff ? br_addr_ff : jmp_addr_ff;

  // load/store request goes out in the same cycle
  assign lsu_op_o    = id.id_valid ? id.lsu_op : LSU_NONE;
  assign lsu_w_o     = id.lsu_w;
  assign lsu_addr_o  = alu_res;
  assign lsu_wdata_o = st_fwd ? wb_value : rs2_data_i;

  // redirect blocks its own successor
  a_single_redirect: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    fetch_req_o |=> !fetch_req_o
  );

  a_hold_on_bp: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    lsu_bp_i |=> $stable(ex_wb_ff)
  );

endmodule

//--- src/id_ex_if.sv
// decode to execute bundle
`timescale 1ns/10ps

interface id_ex_if;
  import rv_exec_pkg::*;

  logic    id_valid;
  rdata_t  pc;
  rdata_t  imm;
  raddr_t  rs1_addr;
  raddr_t  rs2_addr;
  raddr_t  rd_addr;
  op_sel_t rs1_op;
  op_sel_t rs2_op;
  alu_op_t alu_op;
  logic    we_rd;
  logic    branch;
  branch_t branch_op;
  logic    jump;
  lsu_op_t lsu_op;
  lsu_w_t  lsu_w;

  modport src (
    output id_valid, pc, imm, rs1_addr, rs2_addr, rd_addr, rs1_op, rs2_op,
    output alu_op, we_rd, branch, branch_op, jump, lsu_op, lsu_w
  );

  modport dst (
    input id_valid, pc, imm, rs1_addr, rs2_addr, rd_addr, rs1_op, rs2_op,
    input alu_op, we_rd, branch, branch_op, jump, lsu_op, lsu_w
  );

endinterface

//--- src/reg_file.sv
// integer register file
`timescale 1ns/10ps

module reg_file (
  input  logic                clk,
  input  logic                rst_n_i,
  input  rv_exec_pkg::raddr_t rs1_addr_i,
  input  rv_exec_pkg::raddr_t rs2_addr_i,
  output rv_exec_pkg::rdata_t rs1_data_o,
  output rv_exec_pkg::rdata_t rs2_data_o,
  input  logic                we_i,
  input  rv_exec_pkg::raddr_t rd_addr_i,
  input  rv_exec_pkg::rdata_t wdata_i
);
  import rv_exec_pkg::*;

  // x0 has no storage
  rdata_t regs [1:31];

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (rd_addr_i != '0)) begin
      regs[rd_addr_i] <= wdata_i;
    end
  end

  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

  // writes to x0 are filtered on the writeback side
  a_no_x0_write: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    we_i |-> (rd_addr_i != '0)
  );

endmodule

//--- src/rv_exec_pkg.sv
// rv32 execute stage shared types
package rv_exec_pkg;

  localparam int XLEN   = 32;
  localparam int REG_AW = 5;

  typedef logic [XLEN-1:0]   rdata_t;
  typedef logic [REG_AW-1:0] raddr_t;

  // operand source for either alu input
  typedef enum logic [1:0] {
    REG_RF = 2'd0,
    IMM    = 2'd1,
    ZERO   = 2'd2,
    PC     = 2'd3
  } op_sel_t;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLT  = 4'd2,
    ALU_SLTU = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_OR   = 4'd5,
    ALU_AND  = 4'd6,
    ALU_SLL  = 4'd7,
    ALU_SRL  = 4'd8,
    ALU_SRA  = 4'd9
  } alu_op_t;

  // same codes as the branch funct3 field
  typedef enum logic [2:0] {
    RV_B_BEQ  = 3'b000,
    RV_B_BNE  = 3'b001,
    RV_B_BLT  = 3'b100,
    RV_B_BGE  = 3'b101,
    RV_B_BLTU = 3'b110,
    RV_B_BGEU = 3'b111
  } branch_t;

  typedef enum logic [1:0] {
    LSU_NONE  = 2'd0,
    LSU_LOAD  = 2'd1,
    LSU_STORE = 2'd2
  } lsu_op_t;

  typedef enum logic [1:0] {
    LSU_BYTE = 2'd0,
    LSU_HALF = 2'd1,
    LSU_WORD = 2'd2
  } lsu_w_t;

  // execute to writeback record
  typedef struct packed {
    rdata_t result;
    raddr_t rd_addr;
    logic   we_rd;
  } s_ex_wb_t;

  localparam s_ex_wb_t EX_WB_RST = '0;

endpackage

//--- tests/tb_exec_vectors.svh
// execute stage vector table
// columns: test, valid, bp, pc, imm, rs1, rs2, rd, rs1_op, rs2_op, alu_op, we, branch,
// branch_op, jump, lsu_op, lsu_w, then expected result, rd, we, fetch_req, fetch_addr,
// lsu_addr, lsu_wdata

  task automatic load_vectors();
    // x1 = 0x800000f0 then each alu op against an immediate
    rows.push_back('{1, 1, 0, 'h100, 'h800000f0, 0, 0, 1, ZERO, IMM, ALU_ADD, 1, 0,
      RV_B_BEQ, 0, LSU_NONE, LSU_WORD, 'h800000f0, 1, 1, 0, 'h0, 'h0, 'h0});
    rows.push_back('{1, 1, 0, 'h104, 'h10, 1, 0, 2, REG_RF, IMM, ALU_SUB, 1, 0,
      RV_B_BEQ, 0, LSU_NONE, LSU_WORD, 'h800000e0, 2, 1, 0, 'h0, 'h0, 'h0});
    rows.push_back('{1, 1, 0, 'h108, 'h5, 1, 0, 3, REG_RF, IMM, ALU_SLT, 1, 0,
      RV_B_BEQ, 0, LSU_NONE, LSU_WORD, 'h1, 3, 1, 0, 'h0, 'h0, 'h0});
    rows.push_back('{1, 1, 0, 'h10c, 'h5, 1, 0, 4, REG_RF, IMM, ALU_SLTU, 1, 0,
      RV_B_BEQ, 0, LSU_NONE, LSU_WORD, 'h0, 4, 1, 0, 'h0, 'h0, 'h0});
    rows.push_back('{1, 1, 0, 'h110, 'h0f0f0f0f, 1, 0, 5, REG_RF, IMM, ALU_XOR, 1, 0,
      RV_B_BEQ, 0, LSU_NONE, LSU_WORD, 'h8f0f0fff, 5, 1, 0, 'h0, 'h0, 'h0});
    rows.push_back('{1, 1, 0, 'h114, 'h0000ff00, 1, 0, 6, REG_RF, IMM, ALU_OR, 1, 0,
      RV_B_BEQ, 0, LSU_NONE, LSU_WORD, 'h8000fff0, 6, 1, 0, 'h0, 'h0, 'h0});
    rows.push_back('{1, 1, 0, 'h118, 'h000000ff, 1, 0, 7, REG_RF, IMM, ALU_AND, 1, 0,
      RV_B_BEQ, 0, LSU_NONE, LSU_WORD, 'h000000f0, 7, 1, 0, 'h0, 'h0, 'h0});
    // shift amount 0x24 uses only its low five bits
    rows.push_back('{1, 1, 0, 'h11c, 'h24, 1, 0, 8, REG_RF, IMM, ALU_SLL, 1, 0,
      RV_B_BEQ, 0, LSU_NONE, LSU_WORD, 'h00000f00, 8, 1, 0, 'h0, 'h0, 'h0});
    rows.push_back('{1, 1, 0, 'h120, 'h4, 1, 0, 9, REG_RF, IMM, ALU_SRL, 1, 0,
      RV_B_BEQ, 0, LSU_NONE, LSU_WORD, 'h0800000f, 9, 1, 0, 'h0, 'h0, 'h0});
    rows.push_back('{1, 1, 0, 'h124, 'h4, 1, 0, 10, REG_RF, IMM, ALU_SRA, 1, 0,
      RV_B_BEQ, 0, LSU_NONE, LSU_WORD, 'hf800000f, 10, 1, 0, 'h0, 'h0, 'h0});
    // bypass, x0 write, then register file reads
    rows.push_back('{2, 1, 0, 'h128, 'h0, 10, 1, 11, REG_RF, REG_RF, ALU_ADD, 1, 0,
      RV_B_BEQ, 0, LSU_NONE, LSU_WORD, 'h780000ff, 11, 1, 0, 'h0, 'h0, 'h0});
    rows.push_back('{2, 1, 0, 'h12c, 'h55, 0, 0, 0, ZERO, IMM, ALU_ADD, 1, 0,
      RV_B_BEQ, 0, LSU_NONE, LSU_WORD, 'h55, 0, 1, 0, 'h0, 'h0, 'h0});
    rows.push_back('{2, 1, 0, 'h130, 'h0, 0, 11, 12, REG_RF, REG_RF, ALU_ADD, 1, 0,
      RV_B_BEQ, 0, LSU_NONE, LSU_WORD, 'h780000ff, 12, 1, 0, 'h0, 'h0, 'h0});
    rows.push_back('{2, 1, 0, 'h134, 'h0, 1, 12, 13, REG_RF, REG_RF, ALU_SUB, 1, 0,
      RV_B_BEQ, 0, LSU_NONE, LSU_WORD, 'h07fffff1, 13, 1, 0, 'h0, 'h0, 'h0});
    // taken beq, jump in its shadow, bne not taken, jalr and its shadow
    rows.push_back('{3, 1, 0, 'h200, 'h40, 12, 11, 0, REG_RF, REG_RF, ALU_ADD, 0, 1,
      RV_B_BEQ, 0, LSU_NONE, LSU_WORD, 'hf00001fe, 0, 0, 1, 'h240, 'h0, 'h0});
    rows.push_back('{3, 1, 0, 'h204, 'h300, 0, 0, 14, ZERO, IMM, ALU_ADD, 1, 0,
      RV_B_BEQ, 1, LSU_NONE, LSU_WORD, 'h208, 14, 0, 0, 'h0, 'h0, 'h0});
    rows.push_back('{3, 1, 0, 'h300, 'h20, 11, 12, 0, REG_RF, REG_RF, ALU_ADD, 0, 1,
      RV_B_BNE, 0, LSU_NONE, LSU_WORD, 'hf00001fe, 0, 0, 0, 'h0, 'h0, 'h0});
    rows.push_back('{3, 1, 0, 'h400, 'h10, 13, 0, 15, REG_RF, IMM, ALU_ADD, 1, 0,
      RV_B_BEQ, 1, LSU_NONE, LSU_WORD, 'h404, 15, 1, 1, 'h08000000, 'h0, 'h0});
    rows.push_back('{3, 1, 0, 'h404, 'h1, 15, 0, 16, REG_RF, IMM, ALU_ADD, 1, 0,
      RV_B_BEQ, 0, LSU_NONE, LSU_WORD, 'h405, 16, 0, 0, 'h0, 'h0, 'h0});
    // store half with rs2 bypassed from the row before
    rows.push_back('{4, 1, 0, 'h408, 'hcafe, 0, 0, 17, ZERO, IMM, ALU_ADD, 1, 0,
      RV_B_BEQ, 0, LSU_NONE, LSU_WORD, 'hcafe, 17, 1, 0, 'h0, 'h0, 'h0});
    rows.push_back('{4, 1, 0, 'h40c, 'h8, 2, 17, 0, REG_RF, IMM, ALU_ADD, 0, 0,
      RV_B_BEQ, 0, LSU_STORE, LSU_HALF, 'h800000e8, 0, 0, 0, 'h0, 'h800000e8, 'hcafe});
    // two stalled cycles with a taken branch in the second
    rows.push_back('{5, 1, 0, 'h410, 'h1234, 0, 0, 19, ZERO, IMM, ALU_ADD, 1, 0,
      RV_B_BEQ, 0, LSU_NONE, LSU_WORD, 'h1234, 19, 1, 0, 'h0, 'h0, 'h0});
    rows.push_back('{5, 1, 1, 'h414, 'h9999, 0, 0, 20, ZERO, IMM, ALU_ADD, 1, 0,
      RV_B_BEQ, 0, LSU_NONE, LSU_WORD, 'h1234, 19, 1, 0, 'h0, 'h0, 'h0});
    rows.push_back('{5, 1, 1, 'h500, 'h10, 0, 0, 0, REG_RF, REG_RF, ALU_ADD, 0, 1,
      RV_B_BEQ, 0, LSU_NONE, LSU_WORD, 'h1234, 19, 1, 0, 'h0, 'h0, 'h0});
    rows.push_back('{5, 1, 0, 'h414, 'h9999, 0, 0, 20, ZERO, IMM, ALU_ADD, 1, 0,
      RV_B_BEQ, 0, LSU_NONE, LSU_WORD, 'h9999, 20, 1, 0, 'h0, 'h0, 'h0});
    // invalid jump with a store request attached
    rows.push_back('{6, 0, 0, 'h600, 'h700, 0, 0, 21, ZERO, IMM, ALU_ADD, 1, 0,
      RV_B_BEQ, 1, LSU_STORE, LSU_WORD, 'h604, 21, 0, 0, 'h0, 'h0, 'h0});
  endtask

//--- tests/tb_exec_top.sv
// execute stage testbench
`timescale 1ns/10ps

module tb_exec_top;
  import rv_exec_pkg::*;

  typedef struct packed {
    int      test;
    logic    valid;
    logic    bp;
    rdata_t  pc;
    rdata_t  imm;
    raddr_t  rs1;
    raddr_t  rs2;
    raddr_t  rd;
    op_sel_t rs1_op;
    op_sel_t rs2_op;
    alu_op_t alu;
    logic    we;
    logic    br;
    branch_t br_op;
    logic    jmp;
    lsu_op_t lsu;
    lsu_w_t  lsu_w;
    rdata_t  e_res;
    raddr_t  e_rd;
    logic    e_we;
    logic    e_freq;
    rdata_t  e_faddr;
    rdata_t  e_laddr;
    rdata_t  e_lwdata;
  } vec_t;

  localparam int   NUM_TESTS = 6;
  localparam vec_t IDLE_ROW  = '0;

  logic    clk;
  logic    rst_n;
  logic    id_valid;
  rdata_t  pc;
  rdata_t  imm;
  raddr_t  rs1_addr;
  raddr_t  rs2_addr;
  raddr_t  rd_addr;
  op_sel_t rs1_op;
  op_sel_t rs2_op;
  alu_op_t alu_op;
  logic    we_rd;
  logic    branch;
  branch_t branch_op;
  logic    jump;
  lsu_op_t lsu_op;
  lsu_w_t  lsu_w;
  logic    lsu_bp;
  logic    id_ready;
  rdata_t  result;
  raddr_t  wb_rd;
  logic    wb_we;
  logic    fetch_req;
  rdata_t  fetch_addr;
  lsu_op_t lsu_op_out;
  lsu_w_t  lsu_width;
  rdata_t  lsu_addr;
  rdata_t  lsu_wdata;

  vec_t   rows[$];
  int     errors;
  int     checks;
  int     test_err [1:NUM_TESTS];
  rdata_t model_regs [0:31];
  int     cycles;
  int     max_cycles;

  `include "tb_exec_vectors.svh"

  exec_top exec_top_i (
    .clk          (clk),
    .rst_n_i      (rst_n),
    .id_valid_i   (id_valid),
    .pc_i         (pc),
    .imm_i        (imm),
    .rs1_addr_i   (rs1_addr),
    .rs2_addr_i   (rs2_addr),
    .rd_addr_i    (rd_addr),
    .rs1_op_i     (rs1_op),
    .rs2_op_i     (rs2_op),
    .alu_op_i     (alu_op),
    .we_rd_i      (we_rd),
    .branch_i     (branch),
    .branch_op_i  (branch_op),
    .jump_i       (jump),
    .lsu_op_i     (lsu_op),
    .lsu_w_i      (lsu_w),
    .lsu_bp_i     (lsu_bp),
    .id_ready_o   (id_ready),
    .result_o     (result),
    .rd_addr_o    (wb_rd),
    .we_rd_o      (wb_we),
    .fetch_req_o  (fetch_req),
    .fetch_addr_o (fetch_addr),
    .lsu_op_o     (lsu_op_out),
    .lsu_width_o  (lsu_width),
    .lsu_addr_o   (lsu_addr),
    .lsu_wdata_o  (lsu_wdata)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic string test_name(input int t);
    case (t)
      1:       return "alu operations";
      2:       return "forwarding";
      3:       return "branch and jump";
      4:       return "lsu request";
      5:       return "back-pressure";
      default: return "reset and invalid";
    endcase
  endfunction

  task automatic drive_row(input vec_t r);
    id_valid  <= r.valid;
    lsu_bp    <= r.bp;
    pc        <= r.pc;
    imm       <= r.imm;
    rs1_addr  <= r.rs1;
    rs2_addr  <= r.rs2;
    rd_addr   <= r.rd;
    rs1_op    <= r.rs1_op;
    rs2_op    <= r.rs2_op;
    alu_op    <= r.alu;
    we_rd     <= r.we;
    branch    <= r.br;
    branch_op <= r.br_op;
    jump      <= r.jmp;
    lsu_op    <= r.lsu;
    lsu_w     <= r.lsu_w;
  endtask

  task automatic report_mismatch(input string where, input int test, input string name,
                                 input logic [31:0] got, input logic [31:0] exp);
    errors++;
    test_err[test]++;
    $display("** Error %s: %s = %h, expected %h", where, name, got, exp);
  endtask

  // same-cycle outputs sampled mid-cycle
  task automatic check_comb(input int idx, input vec_t r);
    string   where;
    lsu_op_t exp_op;
    where  = $sformatf("row %0d", idx);
    exp_op = r.valid ? r.lsu : LSU_NONE;
    checks += 2;
    if (id_ready !== !r.bp)
      report_mismatch(where, r.test, "id_ready_o", id_ready, !r.bp);
    if (lsu_op_out !== exp_op)
      report_mismatch(where, r.test, "lsu_op_o", lsu_op_out, exp_op);
    if (exp_op != LSU_NONE) begin
      checks += 3;
      if (lsu_width !== r.lsu_w)
        report_mismatch(where, r.test, "lsu_width_o", lsu_width, r.lsu_w);
      if (lsu_addr !== r.e_laddr)
        report_mismatch(where, r.test, "lsu_addr_o", lsu_addr, r.e_laddr);
      if (lsu_wdata !== r.e_lwdata)
        report_mismatch(where, r.test, "lsu_wdata_o", lsu_wdata, r.e_lwdata);
    end
  endtask

  // registered outputs one cycle after the row was sampled
  task automatic check_wb(input int idx, input vec_t r);
    string where;
    where = $sformatf("row %0d", idx);
    checks += 4;
    if (result !== r.e_res) begin
      report_mismatch(where, r.test, "result_o", result, r.e_res);
      $display("   model x%0d holds %h", r.e_rd, model_regs[r.e_rd]);
    end
    if (wb_rd !== r.e_rd)
      report_mismatch(where, r.test, "rd_addr_o", wb_rd, r.e_rd);
    if (wb_we !== r.e_we)
      report_mismatch(where, r.test, "we_rd_o", wb_we, r.e_we);
    if (fetch_req !== r.e_freq)
      report_mismatch(where, r.test, "fetch_req_o", fetch_req, r.e_freq);
    if (r.e_freq) begin
      checks++;
      if (fetch_addr !== r.e_faddr)
        report_mismatch(where, r.test, "fetch_addr_o", fetch_addr, r.e_faddr);
    end
    if (r.e_we && r.e_rd != '0)
      model_regs[r.e_rd] = r.e_res;
  endtask

  task automatic report_test(input int t);
    if (test_err[t] == 0)
      $display("test %0d %s: ok", t, test_name(t));
    else
      $display("test %0d %s: %0d errors", t, test_name(t), test_err[t]);
  endtask

  initial begin : watchdog
    cycles = 0;
    wait (max_cycles > 0);
    while (cycles < max_cycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", max_cycles);
    $display("Testbench failed");
    $finish;
  end

  initial begin : main
    int n;
    errors = 0;
    checks = 0;
    for (int t = 1; t <= NUM_TESTS; t++)
      test_err[t] = 0;
    for (int k = 0; k < 32; k++)
      model_regs[k] = '0;
    load_vectors();
    n = rows.size();
    max_cycles = n * 2 + 20;
    rst_n = 1'b0;
    drive_row(IDLE_ROW);
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);

    // state straight out of reset
    checks += 3;
    if (wb_we !== 1'b0)
      report_mismatch("after reset", 6, "we_rd_o", wb_we, 1'b0);
    if (fetch_req !== 1'b0)
      report_mismatch("after reset", 6, "fetch_req_o", fetch_req, 1'b0);
    if (result !== '0)
      report_mismatch("after reset", 6, "result_o", result, '0);

    // rows go in back to back and the registered check trails by one
    for (int i = 0; i <= n; i++) begin
      @(posedge clk);
      if (i < n)
        drive_row(rows[i]);
      else
        drive_row(IDLE_ROW);
      @(negedge clk);
      if (i < n)
        check_comb(i, rows[i]);
      if (i > 0) begin
        check_wb(i - 1, rows[i-1]);
        if (i == n || rows[i].test != rows[i-1].test)
          report_test(rows[i-1].test);
      end
    end

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+tests
src/rv_exec_pkg.sv
src/id_ex_if.sv
src/exec_alu.sv
src/reg_file.sv
src/execute.sv
src/exec_top.sv
tests/tb_exec_top.sv
